/* design/isa_pkg.sv */
package isa_pkg;

    ////////////////////////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////////////////////////

    // the ten integer operations of the RV32I base set.
    // BEQ is resolved with SUB and the zero flag of the ALU.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    ////////////////////////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////////////////////////

    // format of the decoded instruction.
    // JALR arrives as I_TYPE with is_branch set, JAL as J_TYPE.
    typedef enum logic [2:0] {
        R_TYPE = 3'd0,
        I_TYPE = 3'd1,
        S_TYPE = 3'd2,
        B_TYPE = 3'd3,
        U_TYPE = 3'd4,
        J_TYPE = 3'd5
    } encoding_t;

    // size of one instruction in bytes.
    // The link register of JAL and JALR receives pc plus this value.
    localparam int unsigned ILEN_BYTES = 4;

endpackage

/* design/pipe_pkg.sv */
package pipe_pkg;

    ////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////

    // width of the integer registers and of the datapath.
    localparam int unsigned XLEN = 32;

    // width of a register index, 32 architectural registers.
    localparam int unsigned REG_IDX_W = 5;

    ////////////////////////////////////////////////////////////
    // forwarding
    ////////////////////////////////////////////////////////////

    // source of an ALU operand.
    // MEM holds the younger result and is preferred over WB.
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_t;

endpackage

/* design/alu.sv */
`timescale 1ns/100ps

module alu (
    input  isa_pkg::alu_op_t            alu_op,
    input  logic [pipe_pkg::XLEN-1:0]   left_operand,
    input  logic [pipe_pkg::XLEN-1:0]   right_operand,
    output logic [pipe_pkg::XLEN-1:0]   result,
    output logic                        zero_flag
);

    // shift amount, only the low five bits count on RV32I.
    logic [4:0] shamt;

    assign shamt = right_operand[4:0];

    always_comb begin
        case (alu_op)
            isa_pkg::ALU_ADD: begin
                result = left_operand + right_operand;
            end
            isa_pkg::ALU_SUB: begin
                result = left_operand - right_operand;
            end
            isa_pkg::ALU_AND: begin
                result = left_operand & right_operand;
            end
            isa_pkg::ALU_OR: begin
                result = left_operand | right_operand;
            end
            isa_pkg::ALU_XOR: begin
                result = left_operand ^ right_operand;
            end
            isa_pkg::ALU_SLL: begin
                result = left_operand << shamt;
            end
            isa_pkg::ALU_SRL: begin
                result = left_operand >> shamt;
            end
            isa_pkg::ALU_SRA: begin
                result = $signed(left_operand) >>> shamt;
            end
            isa_pkg::ALU_SLT: begin
                result = {{(pipe_pkg::XLEN-1){1'b0}},
                          $signed(left_operand) < $signed(right_operand)};
            end
            isa_pkg::ALU_SLTU: begin
                result = {{(pipe_pkg::XLEN-1){1'b0}}, left_operand < right_operand};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // BEQ is taken when the difference of the operands is zero.
    assign zero_flag = (result == '0);

endmodule

/* design/forwarding_unit.sv */
`timescale 1ns/100ps

module forwarding_unit (
    input  logic [pipe_pkg::REG_IDX_W-1:0] ex_rs1,
    input  logic [pipe_pkg::REG_IDX_W-1:0] ex_rs2,
    input  logic [pipe_pkg::REG_IDX_W-1:0] mem_rd,
    input  logic [pipe_pkg::REG_IDX_W-1:0] wb_rd,
    input  logic                           mem_reg_write,
    input  logic                           mem_valid,
    input  logic                           wb_reg_write,
    input  logic                           wb_valid,
    output pipe_pkg::fwd_sel_t             forward_a,
    output pipe_pkg::fwd_sel_t             forward_b
);

    // a producer only counts when it holds a live instruction that writes
    // a register other than x0.
    logic mem_produces;
    logic wb_produces;

    assign mem_produces = mem_valid && mem_reg_write && (mem_rd != '0);
    assign wb_produces  = wb_valid && wb_reg_write && (wb_rd != '0);

    // picks the newest in-flight value for one source register.
    // MEM holds the younger result and wins when both stages match.
    function automatic pipe_pkg::fwd_sel_t select_source(
        input logic mem_match,
        input logic wb_match
    );
        if (mem_match) begin
            return pipe_pkg::FWD_MEM;
        end else if (wb_match) begin
            return pipe_pkg::FWD_WB;
        end
        return pipe_pkg::FWD_NONE;
    endfunction

    assign forward_a = select_source(mem_produces && (mem_rd == ex_rs1),
                                     wb_produces && (wb_rd == ex_rs1));
    assign forward_b = select_source(mem_produces && (mem_rd == ex_rs2),
                                     wb_produces && (wb_rd == ex_rs2));

endmodule

/* design/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
    input  logic                        ex_valid,
    input  logic [pipe_pkg::XLEN-1:0]   ex_pc,
    input  logic [pipe_pkg::XLEN-1:0]   ex_rs1_data,
    input  logic [pipe_pkg::XLEN-1:0]   ex_rs2_data,
    input  logic [pipe_pkg::XLEN-1:0]   ex_imm,
    input  isa_pkg::alu_op_t            ex_alu_op,
    input  isa_pkg::encoding_t          ex_encoding,
    input  logic                        ex_alu_src,
    input  logic                        ex_is_branch,
    input  pipe_pkg::fwd_sel_t          forward_a,
    input  pipe_pkg::fwd_sel_t          forward_b,
    input  logic [pipe_pkg::XLEN-1:0]   mem_alu_data,
    input  logic [pipe_pkg::XLEN-1:0]   wb_data,
    output logic [pipe_pkg::XLEN-1:0]   alu_data,
    output logic [pipe_pkg::XLEN-1:0]   store_data,
    output logic                        redirect_valid,
    output logic [pipe_pkg::XLEN-1:0]   redirect_pc
);

    logic [pipe_pkg::XLEN-1:0] left_operand;
    logic [pipe_pkg::XLEN-1:0] rs2_value;
    logic [pipe_pkg::XLEN-1:0] right_operand;
    logic [pipe_pkg::XLEN-1:0] alu_result;
    logic [pipe_pkg::XLEN-1:0] pc_target;
    logic                      zero_flag;
    logic                      is_jal;
    logic                      is_jalr;

    ////////////////////////////////////////////////////////////
    // operand selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (forward_a)
            pipe_pkg::FWD_MEM: left_operand = mem_alu_data;
            pipe_pkg::FWD_WB:  left_operand = wb_data;
            default:           left_operand = ex_rs1_data;
        endcase

        case (forward_b)
            pipe_pkg::FWD_MEM: rs2_value = mem_alu_data;
            pipe_pkg::FWD_WB:  rs2_value = wb_data;
            default:           rs2_value = ex_rs2_data;
        endcase
    end

    // the immediate is applied after forwarding, so a stale rs2 match on an
    // immediate instruction cannot replace the immediate.
    assign right_operand = ex_alu_src ? ex_imm : rs2_value;

    // stores write the forwarded rs2 value, not the one read at issue.
    assign store_data = rs2_value;

    alu i_alu (
        .alu_op        (ex_alu_op),
        .left_operand  (left_operand),
        .right_operand (right_operand),
        .result        (alu_result),
        .zero_flag     (zero_flag)
    );

    ////////////////////////////////////////////////////////////
    // control flow
    ////////////////////////////////////////////////////////////

    assign is_jal    = (ex_encoding == isa_pkg::J_TYPE);
    assign is_jalr   = (ex_encoding == isa_pkg::I_TYPE) && ex_is_branch;
    assign pc_target = ex_pc + ex_imm;

    // jumps write the link address instead of the ALU result.
    assign alu_data = (is_jal || is_jalr) ? ex_pc + pipe_pkg::XLEN'(isa_pkg::ILEN_BYTES)
                                          : alu_result;

    assign redirect_valid = ex_valid && (is_jal || is_jalr ||
                            ((ex_encoding == isa_pkg::B_TYPE) && zero_flag));

    // JALR jumps to rs1 plus imm with the lowest bit cleared.
    assign redirect_pc = is_jalr ? {alu_result[pipe_pkg::XLEN-1:1], 1'b0} : pc_target;

endmodule

/* design/stage_registers.sv */
`timescale 1ns/100ps

module stage_registers (
    input  logic                           clk,
    input  logic                           arst_n,
    // issue port
    input  logic                           issue_valid,
    input  logic [pipe_pkg::XLEN-1:0]      pc,
    input  logic [pipe_pkg::XLEN-1:0]      rs1_data,
    input  logic [pipe_pkg::XLEN-1:0]      rs2_data,
    input  logic [pipe_pkg::XLEN-1:0]      imm,
    input  logic [pipe_pkg::REG_IDX_W-1:0] rs1,
    input  logic [pipe_pkg::REG_IDX_W-1:0] rs2,
    input  logic [pipe_pkg::REG_IDX_W-1:0] rd,
    input  isa_pkg::alu_op_t               alu_op,
    input  isa_pkg::encoding_t             encoding,
    input  logic                           alu_src,
    input  logic                           is_branch,
    input  logic                           reg_write,
    // results of the execute stage
    input  logic                           redirect_valid,
    input  logic [pipe_pkg::XLEN-1:0]      alu_data,
    input  logic [pipe_pkg::XLEN-1:0]      store_data,
    // ID/EX
    output logic                           ex_valid,
    output logic [pipe_pkg::XLEN-1:0]      ex_pc,
    output logic [pipe_pkg::XLEN-1:0]      ex_rs1_data,
    output logic [pipe_pkg::XLEN-1:0]      ex_rs2_data,
    output logic [pipe_pkg::XLEN-1:0]      ex_imm,
    output logic [pipe_pkg::REG_IDX_W-1:0] ex_rs1,
    output logic [pipe_pkg::REG_IDX_W-1:0] ex_rs2,
    output logic [pipe_pkg::REG_IDX_W-1:0] ex_rd,
    output isa_pkg::alu_op_t               ex_alu_op,
    output isa_pkg::encoding_t             ex_encoding,
    output logic                           ex_alu_src,
    output logic                           ex_is_branch,
    output logic                           ex_reg_write,
    // EX/MEM
    output logic                           mem_valid,
    output logic [pipe_pkg::REG_IDX_W-1:0] mem_rd,
    output logic                           mem_reg_write,
    output logic [pipe_pkg::XLEN-1:0]      mem_alu_data,
    output logic [pipe_pkg::XLEN-1:0]      mem_store_data,
    // MEM/WB
    output logic                           wb_valid,
    output logic [pipe_pkg::REG_IDX_W-1:0] wb_rd,
    output logic                           wb_reg_write,
    output logic [pipe_pkg::XLEN-1:0]      wb_data
);

    ////////////////////////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////////////////////////

    // a taken redirect kills the instruction issued in the same cycle.
    // It sits on the wrong path behind the branch.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            ex_valid  <= issue_valid && !redirect_valid;
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
        end
    end

    ////////////////////////////////////////////////////////////
    // payload
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        ex_pc          <= pc;
        ex_rs1_data    <= rs1_data;
        ex_rs2_data    <= rs2_data;
        ex_imm         <= imm;
        ex_rs1         <= rs1;
        ex_rs2         <= rs2;
        ex_rd          <= rd;
        ex_alu_op      <= alu_op;
        ex_encoding    <= encoding;
        ex_alu_src     <= alu_src;
        ex_is_branch   <= is_branch;
        ex_reg_write   <= reg_write;

        mem_rd         <= ex_rd;
        mem_reg_write  <= ex_reg_write;
        mem_alu_data   <= alu_data;
        mem_store_data <= store_data;

        // the MEM stage has no data memory, so the ALU value passes on.
        wb_rd          <= mem_rd;
        wb_reg_write   <= mem_reg_write;
        wb_data        <= mem_alu_data;
    end

endmodule

/* design/ex_pipeline.sv */
`timescale 1ns/100ps

module ex_pipeline (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           issue_valid,
    input  logic [pipe_pkg::XLEN-1:0]      pc,
    input  logic [pipe_pkg::XLEN-1:0]      rs1_data,
    input  logic [pipe_pkg::XLEN-1:0]      rs2_data,
    input  logic [pipe_pkg::XLEN-1:0]      imm,
    input  logic [pipe_pkg::REG_IDX_W-1:0] rs1,
    input  logic [pipe_pkg::REG_IDX_W-1:0] rs2,
    input  logic [pipe_pkg::REG_IDX_W-1:0] rd,
    input  isa_pkg::alu_op_t               alu_op,
    input  isa_pkg::encoding_t             encoding,
    input  logic                           alu_src,
    input  logic                           is_branch,
    input  logic                           reg_write,
    output logic                           redirect_valid,
    output logic [pipe_pkg::XLEN-1:0]      redirect_pc,
    output logic                           wb_valid,
    output logic [pipe_pkg::REG_IDX_W-1:0] wb_rd,
    output logic                           wb_reg_write,
    output logic [pipe_pkg::XLEN-1:0]      wb_data,
    output logic [pipe_pkg::XLEN-1:0]      mem_store_data
);

    logic                           ex_valid;
    logic [pipe_pkg::XLEN-1:0]      ex_pc;
    logic [pipe_pkg::XLEN-1:0]      ex_rs1_data;
    logic [pipe_pkg::XLEN-1:0]      ex_rs2_data;
    logic [pipe_pkg::XLEN-1:0]      ex_imm;
    logic [pipe_pkg::REG_IDX_W-1:0] ex_rs1;
    logic [pipe_pkg::REG_IDX_W-1:0] ex_rs2;
    logic [pipe_pkg::REG_IDX_W-1:0] ex_rd;
    isa_pkg::alu_op_t               ex_alu_op;
    isa_pkg::encoding_t             ex_encoding;
    logic                           ex_alu_src;
    logic                           ex_is_branch;
    logic                           ex_reg_write;
    logic                           mem_valid;
    logic [pipe_pkg::REG_IDX_W-1:0] mem_rd;
    logic                           mem_reg_write;
    logic [pipe_pkg::XLEN-1:0]      mem_alu_data;
    logic [pipe_pkg::XLEN-1:0]      alu_data;
    logic [pipe_pkg::XLEN-1:0]      store_data;
    pipe_pkg::fwd_sel_t             forward_a;
    pipe_pkg::fwd_sel_t             forward_b;

    ////////////////////////////////////////////////////////////
    // pipeline registers
    ////////////////////////////////////////////////////////////

    stage_registers i_stage_registers (
        .clk            (clk),
        .arst_n         (arst_n),
        .issue_valid    (issue_valid),
        .pc             (pc),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .imm            (imm),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd),
        .alu_op         (alu_op),
        .encoding       (encoding),
        .alu_src        (alu_src),
        .is_branch      (is_branch),
        .reg_write      (reg_write),
        .redirect_valid (redirect_valid),
        .alu_data       (alu_data),
        .store_data     (store_data),
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_rs1_data    (ex_rs1_data),
        .ex_rs2_data    (ex_rs2_data),
        .ex_imm         (ex_imm),
        .ex_rs1         (ex_rs1),
        .ex_rs2         (ex_rs2),
        .ex_rd          (ex_rd),
        .ex_alu_op      (ex_alu_op),
        .ex_encoding    (ex_encoding),
        .ex_alu_src     (ex_alu_src),
        .ex_is_branch   (ex_is_branch),
        .ex_reg_write   (ex_reg_write),
        .mem_valid      (mem_valid),
        .mem_rd         (mem_rd),
        .mem_reg_write  (mem_reg_write),
        .mem_alu_data   (mem_alu_data),
        .mem_store_data (mem_store_data),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_reg_write   (wb_reg_write),
        .wb_data        (wb_data)
    );

    ////////////////////////////////////////////////////////////
    // hazard detection and execute
    ////////////////////////////////////////////////////////////

    forwarding_unit i_forwarding_unit (
        .ex_rs1        (ex_rs1),
        .ex_rs2        (ex_rs2),
        .mem_rd        (mem_rd),
        .wb_rd         (wb_rd),
        .mem_reg_write (mem_reg_write),
        .mem_valid     (mem_valid),
        .wb_reg_write  (wb_reg_write),
        .wb_valid      (wb_valid),
        .forward_a     (forward_a),
        .forward_b     (forward_b)
    );

    // the WB forward value is the write-back data itself.
    execute_stage i_execute_stage (
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_rs1_data    (ex_rs1_data),
        .ex_rs2_data    (ex_rs2_data),
        .ex_imm         (ex_imm),
        .ex_alu_op      (ex_alu_op),
        .ex_encoding    (ex_encoding),
        .ex_alu_src     (ex_alu_src),
        .ex_is_branch   (ex_is_branch),
        .forward_a      (forward_a),
        .forward_b      (forward_b),
        .mem_alu_data   (mem_alu_data),
        .wb_data        (wb_data),
        .alu_data       (alu_data),
        .store_data     (store_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* dv/ex_ref_model.svh */
////////////////////////////////////////////////////////////
// model register files
////////////////////////////////////////////////////////////

// architectural state in program order, the source of expected values.
logic [31:0] arch_regs [32];

// state as the DUT has retired it, which drives the issue port.
logic [31:0] retired_regs [32];

////////////////////////////////////////////////////////////
// golden functions
////////////////////////////////////////////////////////////

function automatic logic [31:0] alu_golden(
    input isa_pkg::alu_op_t op,
    input logic [31:0]      a,
    input logic [31:0]      b
);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        isa_pkg::ALU_ADD:  return a + b;
        isa_pkg::ALU_SUB:  return a + ~b + 32'd1;
        isa_pkg::ALU_AND:  return a & b;
        isa_pkg::ALU_OR:   return a | b;
        isa_pkg::ALU_XOR:  return a ^ b;
        isa_pkg::ALU_SLL:  return a << sh;
        isa_pkg::ALU_SRL:  return a >> sh;
        // a logical shift with the vacated bits filled by the sign.
        isa_pkg::ALU_SRA:  return (a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}});
        // flipping the sign bits turns a signed compare into an unsigned one.
        isa_pkg::ALU_SLT:  return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
        isa_pkg::ALU_SLTU: return {31'd0, a < b};
        default:           return 32'd0;
    endcase
endfunction

// JAL and JALR always redirect, BEQ only when both registers are equal.
function automatic logic takes_redirect(
    input isa_pkg::encoding_t enc,
    input logic               br,
    input logic [31:0]        a,
    input logic [31:0]        b
);
    case (enc)
        isa_pkg::J_TYPE: return 1'b1;
        isa_pkg::I_TYPE: return br;
        isa_pkg::B_TYPE: return a == b;
        default:         return 1'b0;
    endcase
endfunction

function automatic logic [31:0] jump_target(
    input isa_pkg::encoding_t enc,
    input logic               br,
    input logic [31:0]        pc_value,
    input logic [31:0]        offset,
    input logic [31:0]        base
);
    if (enc == isa_pkg::I_TYPE && br) begin
        return (base + offset) & ~32'd1;
    end
    return pc_value + offset;
endfunction

// jumps write the address of the next instruction into rd.
function automatic logic [31:0] writeback_value(
    input isa_pkg::alu_op_t   op,
    input isa_pkg::encoding_t enc,
    input logic               br,
    input logic [31:0]        pc_value,
    input logic [31:0]        a,
    input logic [31:0]        b
);
    if (enc == isa_pkg::J_TYPE || (enc == isa_pkg::I_TYPE && br)) begin
        return pc_value + 32'd4;
    end
    return alu_golden(op, a, b);
endfunction

/* dv/ex_pipeline_tb.sv */
`timescale 1ns/100ps

module ex_pipeline_tb;

    typedef struct packed {
        logic [4:0]  rd;
        logic        wr;
        logic [31:0] data;
        logic [31:0] due;
    } wb_entry_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } store_entry_t;

    logic               clk;
    logic               arst_n;
    logic               issue_valid;
    logic [31:0]        pc;
    logic [31:0]        rs1_data;
    logic [31:0]        rs2_data;
    logic [31:0]        imm;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [4:0]         rd;
    isa_pkg::alu_op_t   alu_op;
    isa_pkg::encoding_t encoding;
    logic               alu_src;
    logic               is_branch;
    logic               reg_write;
    logic               redirect_valid;
    logic [31:0]        redirect_pc;
    logic               wb_valid;
    logic [4:0]         wb_rd;
    logic               wb_reg_write;
    logic [31:0]        wb_data;
    logic [31:0]        mem_store_data;

    // expected write-backs in issue order with the head copied out for the checks.
    wb_entry_t    exp_q[$];
    wb_entry_t    head = '0;
    logic         exp_pending = 1'b0;
    logic         any_issued = 1'b0;
    logic         pending_redirect = 1'b0;
    logic [31:0]  pending_target = '0;
    logic         ex_redirect = 1'b0;
    logic [31:0]  ex_target = '0;
    store_entry_t store_pending = '0;
    store_entry_t store_in_ex = '0;
    store_entry_t store_in_mem = '0;
    logic [31:0]  cycle_count = '0;
    logic [31:0]  next_pc = 32'h0000_1000;
    logic [31:0]  lcg_state = 32'hb410_5b38;
    int unsigned  issued = 0;
    int unsigned  checked = 0;
    int unsigned  errors = 0;

    `include "ex_ref_model.svh"

    ex_pipeline i_ex_pipeline (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // a write-back in flight this cycle lands in the register file at the next edge.
    function automatic logic [31:0] read_operand(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return 32'd0;
        end
        if (wb_valid && wb_reg_write && wb_rd == idx) begin
            return wb_data;
        end
        return retired_regs[idx];
    endfunction

    task automatic record_failure(input string msg);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    task automatic refresh_head();
        exp_pending = (exp_q.size() != 0);
        if (exp_pending) begin
            head = exp_q[0];
        end
    endtask

    task automatic issue_instr(
        input isa_pkg::alu_op_t   op,
        input isa_pkg::encoding_t enc,
        input logic               src,
        input logic               br,
        input logic               wr,
        input logic [4:0]         d,
        input logic [4:0]         s1,
        input logic [4:0]         s2,
        input logic [31:0]        immediate
    );
        logic [31:0] a;
        logic [31:0] b;
        wb_entry_t   entry;
        @(posedge clk);
        #1;
        a = arch_regs[s1];
        b = arch_regs[s2];
        issue_valid = 1'b1;
        pc          = next_pc;
        rs1_data    = read_operand(s1);
        rs2_data    = read_operand(s2);
        imm         = immediate;
        rs1         = s1;
        rs2         = s2;
        rd          = d;
        alu_op      = op;
        encoding    = enc;
        alu_src     = src;
        is_branch   = br;
        reg_write   = wr;
        any_issued  = 1'b1;
        issued++;
        // the instruction behind a redirect that the model expects is discarded.
        if (!ex_redirect) begin
            entry.rd   = d;
            entry.wr   = wr;
            entry.data = writeback_value(op, enc, br, next_pc, a, src ? immediate : b);
            entry.due  = cycle_count + 32'd3;
            exp_q.push_back(entry);
            refresh_head();
            if (wr && d != 5'd0) begin
                arch_regs[d] = entry.data;
            end
            pending_redirect    = takes_redirect(enc, br, a, b);
            pending_target      = jump_target(enc, br, next_pc, immediate, a);
            store_pending.valid = (enc == isa_pkg::S_TYPE);
            store_pending.data  = b;
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    // only registers x0 to x7 are used so that dependencies come up often.
    task automatic issue_random();
        logic [31:0]      r;
        logic [31:0]      rand_imm;
        logic [4:0]       d;
        logic [4:0]       s1;
        logic [4:0]       s2;
        isa_pkg::alu_op_t op;
        r        = lcg_next();
        rand_imm = {{20{r[31]}}, r[31:20]};
        d        = {2'b00, r[10:8]};
        s1       = {2'b00, r[13:11]};
        s2       = {2'b00, r[16:14]};
        op       = isa_pkg::alu_op_t'(r[3:0] % 4'd10);
        case (r[6:4])
            3'd0, 3'd1, 3'd2: issue_instr(op, isa_pkg::R_TYPE, 0, 0, 1, d, s1, s2, rand_imm);
            3'd3, 3'd4:       issue_instr(op, isa_pkg::I_TYPE, 1, 0, 1, d, s1, s2, rand_imm);
            3'd5: issue_instr(isa_pkg::ALU_ADD, isa_pkg::S_TYPE, 1, 0, 0, d, s1, s2, rand_imm);
            3'd6: issue_instr(isa_pkg::ALU_SUB, isa_pkg::B_TYPE, 0, 0, 0, d, s1, s2, rand_imm);
            default: begin
                if (r[17]) begin
                    issue_instr(isa_pkg::ALU_ADD, isa_pkg::J_TYPE, 0, 0, 1, d, s1, s2, rand_imm);
                end else begin
                    issue_instr(isa_pkg::ALU_ADD, isa_pkg::I_TYPE, 1, 1, 1, d, s1, s2, rand_imm);
                end
            end
        endcase
    endtask

    task automatic drain_pipeline();
        int unsigned waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timed out with %0d write-backs still missing", exp_q.size());
        end
    endtask

    ////////////////////////////////////////////////////////////
    // monitor
    ////////////////////////////////////////////////////////////

    // runs before the DUT registers update, so it sees the values of the ending cycle.
    always @(posedge clk) begin
        cycle_count = cycle_count + 32'd1;
        if (wb_valid) begin
            checked++;
            if (wb_reg_write && wb_rd != 5'd0) begin
                retired_regs[wb_rd] = wb_data;
            end
            if (exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            refresh_head();
        end
        ex_redirect      = pending_redirect;
        ex_target        = pending_target;
        pending_redirect = 1'b0;
        store_in_mem     = store_in_ex;
        store_in_ex      = store_pending;
        store_pending    = '0;
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
        !any_issued |-> !wb_valid && !redirect_valid)
        else record_failure("write-back or redirect active before the first issue");

    writeback_timing: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid == (exp_pending && cycle_count == head.due))
        else record_failure("write-back missing, extra or not 3 cycles after issue");

    writeback_result: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> wb_rd == head.rd && wb_reg_write == head.wr && wb_data == head.data)
        else record_failure($sformatf("wb_data %h rd %0d, expected %h rd %0d",
            $sampled(wb_data), $sampled(wb_rd), $sampled(head.data), $sampled(head.rd)));

    redirect_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid == ex_redirect)
        else record_failure($sformatf("redirect_valid %b, expected %b",
            $sampled(redirect_valid), $sampled(ex_redirect)));

    redirect_address: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |-> redirect_pc == ex_target)
        else record_failure($sformatf("redirect_pc %h, expected %h",
            $sampled(redirect_pc), $sampled(ex_target)));

    store_value: assert property (@(posedge clk) disable iff (!arst_n)
        store_in_mem.valid |-> mem_store_data == store_in_mem.data)
        else record_failure($sformatf("mem_store_data %h, expected %h",
            $sampled(mem_store_data), $sampled(store_in_mem.data)));

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        arst_n      = 1'b0;
        issue_valid = 1'b0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        imm         = '0;
        rs1         = '0;
        rs2         = '0;
        rd          = '0;
        alu_op      = isa_pkg::ALU_ADD;
        encoding    = isa_pkg::R_TYPE;
        alu_src     = 1'b0;
        is_branch   = 1'b0;
        reg_write   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i]    = '0;
            retired_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (4) idle_cycle();

        for (int k = 1; k < 8; k++) begin
            issue_instr(isa_pkg::ALU_ADD, isa_pkg::I_TYPE, 1, 0, 1, 5'(k), 0, 0, lcg_next());
        end
        for (int k = 0; k < 10; k++) begin
            issue_instr(isa_pkg::alu_op_t'(k), isa_pkg::R_TYPE, 0, 0, 1, 6, 1, 2, '0);
            issue_instr(isa_pkg::alu_op_t'(k), isa_pkg::I_TYPE, 1, 0, 1, 7, 3, 0, lcg_next());
        end

        // x6 is written twice in a row and the newer copy in MEM must win.
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::I_TYPE, 1, 0, 1, 6, 0, 0, 32'd5);
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::I_TYPE, 1, 0, 1, 6, 0, 0, 32'd9);
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::R_TYPE, 0, 0, 1, 7, 6, 6, '0);
        issue_instr(isa_pkg::ALU_SUB, isa_pkg::R_TYPE, 0, 0, 1, 5, 7, 6, '0);
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::I_TYPE, 1, 0, 1, 0, 0, 0, 32'd77);
        issue_instr(isa_pkg::ALU_OR,  isa_pkg::R_TYPE, 0, 0, 1, 5, 0, 0, '0);

        // every taken BEQ, JAL and JALR below is followed by a shadow instruction.
        issue_instr(isa_pkg::ALU_SUB, isa_pkg::B_TYPE, 0, 0, 0, 0, 4, 4, 32'h20);
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::I_TYPE, 1, 0, 1, 1, 0, 0, 32'hdead);
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::I_TYPE, 1, 0, 1, 1, 0, 0, 32'd1);
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::I_TYPE, 1, 0, 1, 2, 0, 0, 32'd2);
        issue_instr(isa_pkg::ALU_SUB, isa_pkg::B_TYPE, 0, 0, 0, 0, 1, 2, 32'h10);
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::J_TYPE, 0, 0, 1, 3, 0, 0, 32'h40);
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::I_TYPE, 1, 0, 1, 5, 0, 0, 32'd5);
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::I_TYPE, 1, 1, 1, 4, 2, 0, 32'd5);
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::I_TYPE, 1, 0, 1, 5, 0, 0, 32'h77);
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::I_TYPE, 1, 0, 1, 5, 0, 0, 32'h55);
        issue_instr(isa_pkg::ALU_ADD, isa_pkg::S_TYPE, 1, 0, 0, 0, 1, 5, 32'd8);

        for (int n = 0; n < 300; n++) begin
            if (lcg_next() % 8 == 0) begin
                idle_cycle();
            end else begin
                issue_random();
            end
        end

        idle_cycle();
        drain_pipeline();
        repeat (2) @(posedge clk);
        #1;
        $display("%0d issued, %0d write-backs seen, %0d errors", issued, checked, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+dv
design/isa_pkg.sv
design/pipe_pkg.sv
design/alu.sv
design/forwarding_unit.sv
design/execute_stage.sv
design/stage_registers.sv
design/ex_pipeline.sv
dv/ex_pipeline_tb.sv
